// ==== Bender.yml ====
package:
  name: shift_unit

sources:
  - hdl/shift_types_pkg.sv
  - hdl/shift_state_pkg.sv
  - hdl/shift_ctrl.sv
  - hdl/shift_reg.sv
  - hdl/overflow_track.sv
  - hdl/shift_unit.sv
  - target: test
    files:
      - testbench/tb_clock.sv
      - testbench/shift_unit_chk.sv
      - testbench/shift_unit_tb.sv

// ==== filelist.f ====
hdl/shift_types_pkg.sv
hdl/shift_state_pkg.sv
hdl/shift_ctrl.sv
hdl/shift_reg.sv
hdl/overflow_track.sv
hdl/shift_unit.sv
testbench/tb_clock.sv
testbench/shift_unit_chk.sv
testbench/shift_unit_tb.sv

// ==== hdl/overflow_track.sv ====
// overflow tracker: last shifted-out bit and sticky 16-bit and 32-bit sign-change flags.
module overflow_track
   import shift_types_pkg::*;
(
   input  logic  clk,
   input  logic  reset,
   input  logic  load,
   input  logic  step_left,
   input  logic  step_right,
   input  data_t value,
   output logic  last_bit,
   output logic  sign_change16,
   output logic  sign_change32
);

   logic sign_diff16;
   logic sign_diff32;

   // a left step loses the sign when the top two bits of a field disagree.
   assign sign_diff16 = value[15] ^ value[14];
   assign sign_diff32 = value[DATA_W-1] ^ value[DATA_W-2];

   always_ff @(posedge clk)
   begin
      if (reset)
      begin
         last_bit      <= 1'b0;
         sign_change16 <= 1'b0;
         sign_change32 <= 1'b0;
      end
      else if (load)
      begin
         last_bit      <= 1'b0;
         sign_change16 <= 1'b0;
         sign_change32 <= 1'b0;
      end
      else if (step_left)
      begin
         last_bit <= value[DATA_W-1];
         // sticky until the next load.
         sign_change16 <= sign_change16 | sign_diff16;
         sign_change32 <= sign_change32 | sign_diff32;
      end
      else if (step_right)
      begin
         // right steps keep the sign, so the flags are left alone.
         last_bit <= value[0];
      end
   end

endmodule

// ==== hdl/shift_ctrl.sv ====
// shift controller: sequencer and step counter that issue load and shift strobes.
module shift_ctrl
   import shift_types_pkg::*;
   import shift_state_pkg::*;
(
   input  logic       clk,
   input  logic       reset,
   input  logic       ready,
   input  shift_amt_u amount,
   output logic       load,
   output logic       step_left,
   output logic       step_right,
   output logic       done
);

   seq_state_e              state;
   seq_state_e              state_next;
   logic signed [AMT_W-1:0] count;
   logic                    dir_neg;
   logic                    amt_zero;
   logic                    last_step;

   // a zero amount has no direction bit and no magnitude.
   // note that -32 has a zero magnitude but the direction bit set.
   assign amt_zero = (amount.fields.mag == '0) && !amount.fields.neg;

   // the step taken with the counter at plus or minus one is the final one.
   assign last_step = dir_neg ? (count == -6'sd1) : (count == 6'sd1);

   // strobes are decoded from the state, so they are mutually exclusive.
   assign load       = (state == IDLE);
   assign step_left  = (state == RUN) && !dir_neg;
   assign step_right = (state == RUN) && dir_neg;
   assign done       = (state == FINISH);

   always_comb
   begin
      state_next = state;
      case (state)
         IDLE:
         begin
            if (ready)
            begin
               state_next = amt_zero ? FINISH : RUN;
            end
         end
         RUN:
         begin
            if (last_step)
            begin
               state_next = FINISH;
            end
         end
         FINISH:
         begin
            // hold the result until the requester lets go of ready.
            if (!ready)
            begin
               state_next = IDLE;
            end
         end
         default:
         begin
            state_next = IDLE;
         end
      endcase
   end

   always_ff @(posedge clk)
   begin
      if (reset)
      begin
         state <= IDLE;
      end
      else
      begin
         state <= state_next;
      end
   end

   // counter and direction follow the amount while idle,
   // so the values in place at the starting edge are the ones used.
   always_ff @(posedge clk)
   begin
      if (reset)
      begin
         count   <= '0;
         dir_neg <= 1'b0;
      end
      else if (state == IDLE)
      begin
         count   <= amount.steps;
         dir_neg <= amount.fields.neg;
      end
      else if (state == RUN)
      begin
         // one unit toward zero per step.
         count <= dir_neg ? count + 6'sd1 : count - 6'sd1;
      end
   end

endmodule

// ==== hdl/shift_reg.sv ====
// shift register: 32-bit operand that loads, shifts left, or shifts right with sign fill.
module shift_reg
   import shift_types_pkg::*;
(
   input  logic  clk,
   input  logic  reset,
   input  logic  load,
   input  logic  step_left,
   input  logic  step_right,
   input  data_t operand,
   output data_t value
);

   data_t value_next;

   always_comb
   begin
      value_next = value;
      if (load)
      begin
         value_next = operand;
      end
      else if (step_left)
      begin
         // zero enters at the bottom.
         value_next = {value[DATA_W-2:0], 1'b0};
      end
      else if (step_right)
      begin
         // sign comes from the register itself, not from the operand input.
         value_next = {value[DATA_W-1], value[DATA_W-1:1]};
      end
   end

   // the result output reads zero after reset.
   always_ff @(posedge clk)
   begin
      if (reset)
      begin
         value <= '0;
      end
      else
      begin
         value <= value_next;
      end
   end

endmodule

// ==== hdl/shift_state_pkg.sv ====
// sequencer state package: state encoding of the shift unit controller.
package shift_state_pkg;

   // idle follows the inputs, run moves one bit per cycle,
   // finish holds the result while ready stays high.
   typedef enum logic [1:0] {
      IDLE   = 2'b00,
      RUN    = 2'b01,
      FINISH = 2'b10
   } seq_state_e;

endpackage

// ==== hdl/shift_types_pkg.sv ====
// shift types package: operand width and the two views of the shift-amount word.
package shift_types_pkg;

   // operand and amount widths.
   localparam int DATA_W = 32;
   localparam int AMT_W  = 6;

   // one 32-bit operand word.
   typedef logic [DATA_W-1:0] data_t;

   // direction and magnitude fields of the amount word.
   // neg set means an arithmetic right shift.
   typedef struct packed {
      logic             neg;
      logic [AMT_W-2:0] mag;
   } shift_fields_t;

   // the amount word is read two ways.
   // the signed view loads the step counter, which then walks toward zero.
   // the fields view gives the direction bit directly.
   typedef union packed {
      logic signed [AMT_W-1:0] steps;
      shift_fields_t           fields;
   } shift_amt_u;

endpackage

// ==== hdl/shift_unit.sv ====
// shift unit top: serial arithmetic shifter built from controller, register and flag tracker.
module shift_unit
   import shift_types_pkg::*;
(
   input  logic       clk,
   input  logic       reset,
   input  logic       ready,
   input  data_t      operand,
   input  shift_amt_u amount,
   output data_t      result,
   output logic       done,
   output logic       last_bit,
   output logic       sign_change16,
   output logic       sign_change32
);

   // strobes from the controller to both datapath blocks.
   logic load;
   logic step_left;
   logic step_right;

   shift_ctrl u_shift_ctrl (
      .clk        (clk),
      .reset      (reset),
      .ready      (ready),
      .amount     (amount),
      .load       (load),
      .step_left  (step_left),
      .step_right (step_right),
      .done       (done)
   );

   // the register value is the result and also feeds the flag tracker.
   shift_reg u_shift_reg (
      .clk        (clk),
      .reset      (reset),
      .load       (load),
      .step_left  (step_left),
      .step_right (step_right),
      .operand    (operand),
      .value      (result)
   );

   overflow_track u_overflow_track (
      .clk           (clk),
      .reset         (reset),
      .load          (load),
      .step_left     (step_left),
      .step_right    (step_right),
      .value         (result),
      .last_bit      (last_bit),
      .sign_change16 (sign_change16),
      .sign_change32 (sign_change32)
   );

endmodule

// ==== testbench/shift_input.txt ====
# columns: name operand(hex) amount(signed decimal) result(hex) last_bit sign_change16 sign_change32
# positive amounts shift left, negative amounts shift right with sign fill
shl1_one 00000001 1 00000002 0 0 0
shl31_one 00000001 31 80000000 0 1 1
shl4_pat 12345678 4 23456780 1 1 1
shl8_ff 000000FF 8 0000FF00 0 1 0
shl16_neg FFFF8000 16 80000000 1 1 0
shl31_ones FFFFFFFF 31 80000000 1 1 0
shl3_bit30 40000000 3 00000000 0 0 1
shl1_top C0000001 1 80000002 1 0 0
sar1_pos 12345678 -1 091A2B3C 0 0 0
sar4_neg 87654321 -4 F8765432 0 0 0
sar4_pat 12345678 -4 01234567 1 0 0
sar3_bit30 40000000 -3 08000000 0 0 0
sar32_neg 80000001 -32 FFFFFFFF 1 0 0
sar32_pos 7FFFFFFF -32 00000000 0 0 0
sar31_pos 7FFFFFFF -31 00000000 1 0 0
zero_amt DEADBEEF 0 DEADBEEF 0 0 0
zero_disagree 40004000 0 40004000 0 0 0
sar16_neg FFFF0000 -16 FFFFFFFF 0 0 0

// ==== testbench/shift_unit_chk.sv ====
// sequencer checker: concurrent assertions on the shift controller state and strobes.
module shift_unit_chk
   import shift_state_pkg::*;
(
   input logic       clk,
   input logic       reset,
   input logic       ready,
   input seq_state_e state,
   input logic       load,
   input logic       step_left,
   input logic       step_right,
   input logic       done
);

   // the result is held as long as the requester keeps ready high.
   a_finish_holds: assert property (@(posedge clk) disable iff (reset)
      (state == FINISH) && ready |=> (state == FINISH) && done)
      else $error("finish state left while ready was held");

   // the first edge without ready goes back to idle and drops done.
   a_finish_releases: assert property (@(posedge clk) disable iff (reset)
      (state == FINISH) && !ready |=> (state == IDLE) && load && !done)
      else $error("finish state did not return to idle after ready fell");

   // a run keeps one direction and ends only in the finish state.
   a_steps_steady: assert property (@(posedge clk) disable iff (reset)
      (step_left || step_right) |=>
         done || ({step_left, step_right} == $past({step_left, step_right})))
      else $error("step direction changed or run ended outside the finish state");

   a_done_after_reset: assert property (@(posedge clk) reset |=> !done)
      else $error("done high in the cycle after reset");

endmodule

bind shift_ctrl shift_unit_chk u_shift_unit_chk (
   .clk        (clk),
   .reset      (reset),
   .ready      (ready),
   .state      (state),
   .load       (load),
   .step_left  (step_left),
   .step_right (step_right),
   .done       (done)
);

// ==== testbench/shift_unit_tb.sv ====
// shift unit testbench: runs file vectors through the serial shifter and checks results and timing.
module shift_unit_tb
   import shift_types_pkg::*;
;

   logic       clk;
   logic       reset;
   logic       ready;
   data_t      operand;
   shift_amt_u amount;
   data_t      result;
   logic       done;
   logic       last_bit;
   logic       sign_change16;
   logic       sign_change32;

   int          errors;
   int          checks;
   bit          timed_out;
   int          fd;
   int          code;
   string       line;

   // last vector read from the file.
   string       v_name;
   logic [31:0] v_op;
   int          v_amt;
   logic [31:0] v_res;
   logic        v_lb;
   logic        v_s16;
   logic        v_s32;

   // left shift with every flag set, replayed around a reset.
   string       r_name;
   logic [31:0] r_op;
   int          r_amt;
   logic [31:0] r_res;
   bit          r_found;

   tb_clock #(.PERIOD(10)) u_tb_clock (.clk(clk));

   shift_unit u_shift_unit (
      .clk           (clk),
      .reset         (reset),
      .ready         (ready),
      .operand       (operand),
      .amount        (amount),
      .result        (result),
      .done          (done),
      .last_bit      (last_bit),
      .sign_change16 (sign_change16),
      .sign_change32 (sign_change32)
   );

   task automatic compare(input string name, input string what,
                          input logic [31:0] expected, input logic [31:0] actual);
      checks++;
      if (actual !== expected)
      begin
         $display("CHECK FAILED %s %s: expected %h, actual %h", name, what, expected, actual);
         errors++;
      end
   endtask

   task automatic check_outputs(input string name, input logic [31:0] res,
                                input logic lb, input logic s16, input logic s32);
      compare(name, "done", 32'(1'b1), 32'(done));
      compare(name, "result", res, result);
      compare(name, "last_bit", 32'(lb), 32'(last_bit));
      compare(name, "sign_change16", 32'(s16), 32'(sign_change16));
      compare(name, "sign_change32", 32'(s32), 32'(sign_change32));
   endtask

   task automatic run_op(input string name, input logic [31:0] op, input int amt,
                         input logic [31:0] res, input logic lb, input logic s16, input logic s32);
      int          n;
      int          steps;
      int          hold;
      logic [31:0] rnd;
      n = (amt < 0) ? -amt : amt;
      @(posedge clk);
      ready        <= 1'b1;
      operand      <= op;
      amount.steps <= amt[AMT_W-1:0];
      // this edge samples ready, so the inputs may change from here on.
      @(posedge clk);
      rnd = $urandom;
      operand      <= ~op;
      amount.steps <= rnd[AMT_W-1:0];
      steps = 0;
      @(negedge clk);
      while (!done && steps < 64)
      begin
         @(negedge clk);
         steps++;
      end
      if (!done)
      begin
         $display("%s: done never rose within 64 cycles", name);
         errors++;
         timed_out = 1'b1;
      end
      else
      begin
         compare(name, "latency", 32'(n), 32'(steps));
         check_outputs(name, res, lb, s16, s32);
         hold = $urandom % 4;
         repeat (hold)
         begin
            @(negedge clk);
            check_outputs(name, res, lb, s16, s32);
         end
         @(posedge clk);
         ready <= 1'b0;
         @(negedge clk);
         compare(name, "done before drop", 32'(1'b1), 32'(done));
         @(negedge clk);
         compare(name, "done after drop", 32'(1'b0), 32'(done));
         repeat ($urandom % 4) @(posedge clk);
      end
   endtask

   // reset lands on the edge that would take the last step.
   task automatic reset_mid_op();
      @(posedge clk);
      ready        <= 1'b1;
      operand      <= r_op;
      amount.steps <= r_amt[AMT_W-1:0];
      repeat (r_amt) @(posedge clk);
      reset <= 1'b1;
      ready <= 1'b0;
      @(posedge clk);
      @(negedge clk);
      compare("reset_mid", "done", 32'(1'b0), 32'(done));
      compare("reset_mid", "result", 32'h0, result);
      compare("reset_mid", "last_bit", 32'(1'b0), 32'(last_bit));
      compare("reset_mid", "sign_change16", 32'(1'b0), 32'(sign_change16));
      compare("reset_mid", "sign_change32", 32'(1'b0), 32'(sign_change32));
      @(posedge clk);
      reset <= 1'b0;
      run_op({r_name, "_after_reset"}, r_op, r_amt, r_res, 1'b1, 1'b1, 1'b1);
   endtask

   initial
   begin
      reset     = 1'b1;
      ready     = 1'b0;
      operand   = '0;
      amount    = '0;
      errors    = 0;
      checks    = 0;
      timed_out = 1'b0;
      r_found   = 1'b0;
      void'($urandom(32'h49791c41));
      repeat (8) @(posedge clk);
      reset <= 1'b0;
      fd = $fopen("testbench/shift_input.txt", "r");
      if (fd == 0)
      begin
         $display("could not open the vector file testbench/shift_input.txt");
         errors++;
      end
      else
      begin
         while (!timed_out && $fgets(line, fd) != 0)
         begin
            if (line.len() > 1 && line[0] != "#")
            begin
               code = $sscanf(line, "%s %h %d %h %b %b %b",
                              v_name, v_op, v_amt, v_res, v_lb, v_s16, v_s32);
               if (code != 7)
               begin
                  $display("could not parse vector line: %s", line);
                  errors++;
               end
               else
               begin
                  run_op(v_name, v_op, v_amt, v_res, v_lb, v_s16, v_s32);
                  if (v_amt > 0 && v_lb && v_s16 && v_s32)
                  begin
                     r_name  = v_name;
                     r_op    = v_op;
                     r_amt   = v_amt;
                     r_res   = v_res;
                     r_found = 1'b1;
                  end
               end
            end
         end
         $fclose(fd);
         if (!timed_out)
         begin
            if (r_found)
            begin
               reset_mid_op();
            end
            else
            begin
               $display("no left shift vector with all flags set for the reset test");
               errors++;
            end
         end
      end
      $display("%0d checks, %0d errors", checks, errors);
      if (errors == 0)
      begin
         $display("Verification passed");
      end
      else
      begin
         $display("Verification failed");
      end
      $finish;
   end

endmodule

// ==== testbench/tb_clock.sv ====
// testbench clock: free-running clock for the shift unit testbench.
module tb_clock
#(
   parameter int PERIOD = 10
)
(
   output logic clk
);

   initial
   begin
      clk = 1'b0;
   end

   always
   begin
      #(PERIOD / 2) clk = ~clk;
   end

endmodule
